// File: hw/pkt_pkg.sv
package pkt_pkg;

  // Stream byte width
  localparam int DATA_W = 8;

  // Packet memory size, any power of two from 16 up
  localparam int FIFO_DEPTH = 32;
  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  // CRC-8, MSB first
  localparam logic [DATA_W-1:0] CRC_POLY = 8'h07;
  localparam logic [DATA_W-1:0] CRC_INIT = 8'h00;

  // Receive side of crc_check
  typedef enum logic {
    RX_EMPTY = 1'b0,
    RX_HOLD  = 1'b1
  } rx_state_e;

  // Transmit gate of ack_tracker
  typedef enum logic {
    TX_SEND = 1'b0,
    TX_WAIT = 1'b1
  } tx_state_e;

  // Response opcode from the far end
  typedef enum logic {
    ACK_OK  = 1'b0,
    ACK_NAK = 1'b1
  } ack_code_e;

endpackage

// File: hw/crc_check.sv
`timescale 1ns/1ps

module crc_check (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       rx_valid_i,
  output logic                       rx_ready_o,
  input  logic                       rx_last_i,
  input  logic [pkt_pkg::DATA_W-1:0] rx_data_i,
  output logic                       wr_valid_o,
  input  logic                       wr_ready_i,
  output logic                       wr_last_o,
  output logic [pkt_pkg::DATA_W-1:0] wr_data_o,
  output logic                       commit_o,
  output logic                       drop_o
);

  pkt_pkg::rx_state_e          state_q;
  logic [pkt_pkg::DATA_W-1:0]  hold_q;
  logic [pkt_pkg::DATA_W-1:0]  crc_q;
  logic                        rx_fire;
  logic                        frame_end;
  logic                        crc_ok;

  // One byte of CRC-8, shifted in MSB first
  function automatic logic [pkt_pkg::DATA_W-1:0] crc_byte(
    input logic [pkt_pkg::DATA_W-1:0] crc,
    input logic [pkt_pkg::DATA_W-1:0] data
  );
    logic [pkt_pkg::DATA_W-1:0] c;
    c = crc ^ data;
    for (int i = 0; i < pkt_pkg::DATA_W; i++) begin
      if (c[pkt_pkg::DATA_W-1]) begin
        c = (c << 1) ^ pkt_pkg::CRC_POLY;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

  // Empty: always take a byte. Holding: the held byte must leave first
  assign rx_ready_o = (state_q == pkt_pkg::RX_EMPTY) ? 1'b1 : wr_ready_i;
  assign rx_fire    = rx_valid_i && rx_ready_o;

  // Held byte goes out as the next byte comes in
  assign wr_valid_o = (state_q == pkt_pkg::RX_HOLD) && rx_valid_i;
  assign wr_last_o  = rx_last_i;
  assign wr_data_o  = hold_q;

  // Incoming byte is the CRC, the running value covers every data byte
  assign crc_ok    = (crc_q == rx_data_i);
  assign frame_end = wr_valid_o && wr_ready_i && rx_last_i;
  assign commit_o  = frame_end && crc_ok;
  assign drop_o    = frame_end && !crc_ok;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= pkt_pkg::RX_EMPTY;
      crc_q   <= pkt_pkg::CRC_INIT;
    end else if (rx_fire) begin
      if (rx_last_i) begin
        // Also swallows a frame with no data bytes
        state_q <= pkt_pkg::RX_EMPTY;
        crc_q   <= pkt_pkg::CRC_INIT;
      end else begin
        state_q <= pkt_pkg::RX_HOLD;
        crc_q   <= crc_byte(crc_q, rx_data_i);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rx_fire && !rx_last_i) begin
      hold_q <= rx_data_i;
    end
  end

endmodule

// File: hw/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       wr_valid_i,
  output logic                       wr_ready_o,
  input  logic                       wr_last_i,
  input  logic [pkt_pkg::DATA_W-1:0] wr_data_i,
  input  logic                       commit_i,
  input  logic                       drop_i,
  output logic                       rd_valid_o,
  input  logic                       rd_ready_i,
  output logic                       rd_last_o,
  output logic [pkt_pkg::DATA_W-1:0] rd_data_o,
  input  logic                       release_i,
  input  logic                       replay_i,
  output logic [pkt_pkg::ADDR_W-1:0] level_o
);

  // Each word is {last, data}
  logic [pkt_pkg::DATA_W:0] mem [pkt_pkg::FIFO_DEPTH];

  // Pointers carry one wrap bit above the address
  logic [pkt_pkg::ADDR_W:0] wr_ptr;
  logic [pkt_pkg::ADDR_W:0] pkt_mark;
  logic [pkt_pkg::ADDR_W:0] rd_ptr;
  logic [pkt_pkg::ADDR_W:0] rep_mark;

  logic [pkt_pkg::ADDR_W:0] wr_ptr_d;
  logic [pkt_pkg::ADDR_W:0] pkt_mark_d;
  logic [pkt_pkg::ADDR_W:0] rd_ptr_d;
  logic [pkt_pkg::ADDR_W:0] used_d;
  logic [pkt_pkg::ADDR_W:0] level_d;

  logic                     wr_ready_q;
  logic                     rd_valid_q;
  logic [pkt_pkg::ADDR_W-1:0] level_q;
  logic                     wr_fire;
  logic                     rd_fire;

  assign wr_ready_o = wr_ready_q;
  assign rd_valid_o = rd_valid_q;
  assign level_o    = level_q;

  assign wr_fire = wr_valid_i && wr_ready_q;
  assign rd_fire = rd_valid_q && rd_ready_i;

  // Write side

  always_comb begin
    if (drop_i) begin
      // Discard everything since the last commit
      wr_ptr_d = pkt_mark;
    end else if (wr_fire) begin
      wr_ptr_d = wr_ptr + 1'b1;
    end else begin
      wr_ptr_d = wr_ptr;
    end
  end

  // Commit arrives with the last write, so it takes the advanced pointer
  assign pkt_mark_d = (commit_i && !drop_i) ? wr_ptr_d : pkt_mark;

  // Space is counted from the replay mark, so unreleased bytes stay intact
  assign used_d = wr_ptr_d - rep_mark;

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem[wr_ptr[pkt_pkg::ADDR_W-1:0]] <= {wr_last_i, wr_data_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr     <= '0;
      pkt_mark   <= '0;
      wr_ready_q <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr_d;
      pkt_mark   <= pkt_mark_d;
      // One entry is kept free so the level fits in ADDR_W bits
      wr_ready_q <= (used_d < pkt_pkg::FIFO_DEPTH - 1);
    end
  end

  // Read side

  always_comb begin
    if (replay_i) begin
      rd_ptr_d = rep_mark;
    end else if (rd_fire) begin
      rd_ptr_d = rd_ptr + 1'b1;
    end else begin
      rd_ptr_d = rd_ptr;
    end
  end

  // Asynchronous read, the tracker consumes straight from memory
  assign {rd_last_o, rd_data_o} = mem[rd_ptr[pkt_pkg::ADDR_W-1:0]];

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr     <= '0;
      rep_mark   <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_ptr <= rd_ptr_d;

      // Release keeps the start of the next packet as the new replay point
      if (release_i) begin
        rep_mark <= rd_ptr;
      end

      // Only committed bytes are readable. A replay forces one idle cycle
      rd_valid_q <= !replay_i && (rd_ptr_d != pkt_mark);
    end
  end

  // Committed and not yet read
  assign level_d = pkt_mark_d - rd_ptr_d;

  always_ff @(posedge clock) begin
    if (reset) begin
      level_q <= '0;
    end else begin
      level_q <= level_d[pkt_pkg::ADDR_W-1:0];
    end
  end

endmodule

// File: hw/ack_tracker.sv
`timescale 1ns/1ps

module ack_tracker (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       rd_valid_i,
  output logic                       rd_ready_o,
  input  logic                       rd_last_i,
  input  logic [pkt_pkg::DATA_W-1:0] rd_data_i,
  output logic                       tx_valid_o,
  input  logic                       tx_ready_i,
  output logic                       tx_last_o,
  output logic [pkt_pkg::DATA_W-1:0] tx_data_o,
  input  logic                       resp_valid_i,
  input  pkt_pkg::ack_code_e         resp_code_i,
  output logic                       release_o,
  output logic                       replay_o
);

  pkt_pkg::tx_state_e state_q;
  logic               release_q;
  logic               replay_q;
  logic               send_en;
  logic               tx_fire;
  logic               resp_take;

  // Gate stays shut while the FIFO rewinds its read pointer
  assign send_en = (state_q == pkt_pkg::TX_SEND) && !replay_q;

  assign tx_valid_o = rd_valid_i && send_en;
  assign tx_last_o  = rd_last_i;
  assign tx_data_o  = rd_data_i;
  assign rd_ready_o = tx_ready_i && send_en;

  assign tx_fire = tx_valid_o && tx_ready_i;

  // Responses only count while a packet is outstanding
  assign resp_take = resp_valid_i && (state_q == pkt_pkg::TX_WAIT);

  assign release_o = release_q;
  assign replay_o  = replay_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q   <= pkt_pkg::TX_SEND;
      release_q <= 1'b0;
      replay_q  <= 1'b0;
    end else begin
      release_q <= resp_take && (resp_code_i == pkt_pkg::ACK_OK);
      replay_q  <= resp_take && (resp_code_i == pkt_pkg::ACK_NAK);

      case (state_q)
        pkt_pkg::TX_SEND: begin
          // Stop after the last byte of every packet
          if (tx_fire && rd_last_i) begin
            state_q <= pkt_pkg::TX_WAIT;
          end
        end
        pkt_pkg::TX_WAIT: begin
          if (resp_take) begin
            state_q <= pkt_pkg::TX_SEND;
          end
        end
        default: begin
          state_q <= pkt_pkg::TX_SEND;
        end
      endcase
    end
  end

endmodule

// File: hw/link_buffer.sv
`timescale 1ns/1ps

module link_buffer (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       rx_valid_i,
  output logic                       rx_ready_o,
  input  logic                       rx_last_i,
  input  logic [pkt_pkg::DATA_W-1:0] rx_data_i,
  output logic                       tx_valid_o,
  input  logic                       tx_ready_i,
  output logic                       tx_last_o,
  output logic [pkt_pkg::DATA_W-1:0] tx_data_o,
  input  logic                       resp_valid_i,
  input  pkt_pkg::ack_code_e         resp_code_i,
  output logic [pkt_pkg::ADDR_W-1:0] level_o
);

  // Checker to FIFO
  logic                       wr_valid;
  logic                       wr_ready;
  logic                       wr_last;
  logic [pkt_pkg::DATA_W-1:0] wr_data;
  logic                       commit;
  logic                       drop;

  // FIFO to tracker
  logic                       rd_valid;
  logic                       rd_ready;
  logic                       rd_last;
  logic [pkt_pkg::DATA_W-1:0] rd_data;
  logic                       pkt_release;
  logic                       pkt_replay;

  crc_check u_crc_check (
    .clock      (clock),
    .reset      (reset),
    .rx_valid_i (rx_valid_i),
    .rx_ready_o (rx_ready_o),
    .rx_last_i  (rx_last_i),
    .rx_data_i  (rx_data_i),
    .wr_valid_o (wr_valid),
    .wr_ready_i (wr_ready),
    .wr_last_o  (wr_last),
    .wr_data_o  (wr_data),
    .commit_o   (commit),
    .drop_o     (drop)
  );

  packet_fifo u_packet_fifo (
    .clock      (clock),
    .reset      (reset),
    .wr_valid_i (wr_valid),
    .wr_ready_o (wr_ready),
    .wr_last_i  (wr_last),
    .wr_data_i  (wr_data),
    .commit_i   (commit),
    .drop_i     (drop),
    .rd_valid_o (rd_valid),
    .rd_ready_i (rd_ready),
    .rd_last_o  (rd_last),
    .rd_data_o  (rd_data),
    .release_i  (pkt_release),
    .replay_i   (pkt_replay),
    .level_o    (level_o)
  );

  ack_tracker u_ack_tracker (
    .clock        (clock),
    .reset        (reset),
    .rd_valid_i   (rd_valid),
    .rd_ready_o   (rd_ready),
    .rd_last_i    (rd_last),
    .rd_data_i    (rd_data),
    .tx_valid_o   (tx_valid_o),
    .tx_ready_i   (tx_ready_i),
    .tx_last_o    (tx_last_o),
    .tx_data_o    (tx_data_o),
    .resp_valid_i (resp_valid_i),
    .resp_code_i  (resp_code_i),
    .release_o    (pkt_release),
    .replay_o     (pkt_replay)
  );

endmodule

// File: sim/link_properties.sv
`timescale 1ns/1ps

module link_properties (
  input logic                     clock,
  input logic                     reset,
  input logic                     release_i,
  input logic                     replay_i,
  input logic                     tx_valid_i,
  input logic                     tx_ready_i,
  input logic                     tx_last_i,
  input logic                     resp_valid_i,
  input logic [pkt_pkg::ADDR_W:0] level_i
);

  int unsigned fail_count = 0;
  logic        waiting;

  // Outstanding packet as seen from the link side
  always_ff @(posedge clock) begin
    if (reset) begin
      waiting <= 1'b0;
    end else if (resp_valid_i) begin
      waiting <= 1'b0;
    end else if (tx_valid_i && tx_ready_i && tx_last_i) begin
      waiting <= 1'b1;
    end
  end

  // One response gives one strobe, one cycle wide
  strobes_exclusive: assert property (@(posedge clock) disable iff (reset)
    (release_i || replay_i) |-> !(release_i && replay_i) ##1 !(release_i || replay_i))
    else begin
      $error("release and replay are not a single one-cycle strobe");
      fail_count++;
    end

  // Output gate is shut while a response is outstanding
  gate_closed_in_wait: assert property (@(posedge clock) disable iff (reset)
    waiting |-> !tx_valid_i)
    else begin
      $error("tx_valid is high while waiting for a response");
      fail_count++;
    end

  // Rewind of the read pointer costs one idle cycle on tx
  idle_after_replay: assert property (@(posedge clock) disable iff (reset)
    replay_i |=> !tx_valid_i)
    else begin
      $error("tx_valid is high in the cycle after a replay");
      fail_count++;
    end

  // Unwrapped distance from the read pointer to the packet mark
  level_in_range: assert property (@(posedge clock) disable iff (reset)
    level_i <= pkt_pkg::FIFO_DEPTH - 1)
    else begin
      $error("level is above the usable FIFO depth");
      fail_count++;
    end

endmodule

bind link_buffer link_properties u_link_props (
  .clock        (clock),
  .reset        (reset),
  .release_i    (pkt_release),
  .replay_i     (pkt_replay),
  .tx_valid_i   (tx_valid_o),
  .tx_ready_i   (tx_ready_i),
  .tx_last_i    (tx_last_o),
  .resp_valid_i (resp_valid_i),
  .level_i      (u_packet_fifo.level_d)
);

// File: sim/link_tb.sv
`timescale 1ns/1ps

module link_tb;

  localparam int MAX_FRAME  = 16;
  localparam int NUM_FRAMES = 40;
  localparam int TIMEOUT    = 2000;
  localparam int FILL_STALL = 200;

  logic                       clock = 1'b0;
  logic                       reset;
  logic                       rx_valid;
  logic                       rx_ready;
  logic                       rx_last;
  logic [pkt_pkg::DATA_W-1:0] rx_data;
  logic                       tx_valid;
  logic                       tx_ready;
  logic                       tx_last;
  logic [pkt_pkg::DATA_W-1:0] tx_data;
  logic                       resp_valid;
  pkt_pkg::ack_code_e         resp_code;
  logic [pkt_pkg::ADDR_W-1:0] level;

  integer seed;
  logic   saw_backpressure;

  // Receive stream, CRC byte included
  logic [pkt_pkg::DATA_W-1:0] stream_data [$];
  logic                       stream_last [$];
  // Good frames only, without their CRC byte
  logic [pkt_pkg::DATA_W-1:0] exp_data [$];
  int                         exp_len [$];

  link_buffer i_dut (
    .clock        (clock),
    .reset        (reset),
    .rx_valid_i   (rx_valid),
    .rx_ready_o   (rx_ready),
    .rx_last_i    (rx_last),
    .rx_data_i    (rx_data),
    .tx_valid_o   (tx_valid),
    .tx_ready_i   (tx_ready),
    .tx_last_o    (tx_last),
    .tx_data_o    (tx_data),
    .resp_valid_i (resp_valid),
    .resp_code_i  (resp_code),
    .level_o      (level)
  );

  always #2 clock = ~clock;

  // Bit-serial CRC-8, feedback from the top bit
  function automatic logic [pkt_pkg::DATA_W-1:0] crc8_update(
    input logic [pkt_pkg::DATA_W-1:0] crc,
    input logic [pkt_pkg::DATA_W-1:0] data
  );
    logic [pkt_pkg::DATA_W-1:0] c;
    logic                       fb;
    c = crc;
    for (int i = pkt_pkg::DATA_W - 1; i >= 0; i--) begin
      fb = c[pkt_pkg::DATA_W-1] ^ data[i];
      c = {c[pkt_pkg::DATA_W-2:0], 1'b0};
      if (fb) begin
        c = c ^ pkt_pkg::CRC_POLY;
      end
    end
    return c;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("SIMULATION FAILED");
    $fatal(1, "Wait loop timed out");
  endtask

  task automatic build_frames();
    int                         len;
    logic                       bad;
    logic [pkt_pkg::DATA_W-1:0] crc;
    logic [pkt_pkg::DATA_W-1:0] b;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      len = 2 + ($unsigned($random(seed)) % (MAX_FRAME - 1));
      bad = (($random(seed) & 3) == 0);
      crc = pkt_pkg::CRC_INIT;
      for (int i = 0; i < len - 1; i++) begin
        b = $random(seed);
        crc = crc8_update(crc, b);
        stream_data.push_back(b);
        stream_last.push_back(1'b0);
        if (!bad) begin
          exp_data.push_back(b);
        end
      end
      // Flip at least one CRC bit
      if (bad) begin
        crc = crc ^ (1 + ($unsigned($random(seed)) % 255));
      end else begin
        exp_len.push_back(len - 1);
      end
      stream_data.push_back(crc);
      stream_last.push_back(1'b1);
    end
  endtask

  task automatic drive_rx();
    int gap;
    int waited;
    for (int i = 0; i < stream_data.size(); i++) begin
      gap = $unsigned($random(seed)) % 3;
      for (int g = 0; g < gap; g++) begin
        @(negedge clock);
        rx_valid = 1'b0;
      end
      @(negedge clock);
      rx_valid = 1'b1;
      rx_data  = stream_data[i];
      rx_last  = stream_last[i];
      #1;
      // Valid stays up until the byte is taken
      waited = 0;
      while (!rx_ready) begin
        saw_backpressure = 1'b1;
        @(negedge clock);
        #1;
        waited++;
        if (waited > TIMEOUT) begin
          report_timeout("A receive byte was never accepted.");
        end
      end
    end
    @(negedge clock);
    rx_valid = 1'b0;
  endtask

  task automatic receive_tx();
    int   pkt;
    int   idx;
    int   waited;
    int   delay;
    logic got_last;
    pkt = 0;

    // Nothing leaves at first, so the FIFO fills and rx sees back-pressure
    for (int s = 0; s < FILL_STALL; s++) begin
      @(negedge clock);
      tx_ready = 1'b0;
    end

    while (exp_len.size() > 0) begin
      idx      = 0;
      got_last = 1'b0;
      waited   = 0;
      while (!got_last) begin
        @(negedge clock);
        resp_valid = 1'b0;
        tx_ready   = (($random(seed) & 3) != 0);
        #1;
        if (tx_valid && tx_ready) begin
          check_value($sformatf("packet %0d byte %0d data", pkt, idx), exp_data[idx], tx_data);
          check_value($sformatf("packet %0d byte %0d last", pkt, idx),
                      idx == exp_len[0] - 1, tx_last);
          // The rest of this packet is committed and still unread
          check_value($sformatf("packet %0d byte %0d level", pkt, idx), 1,
                      level >= exp_len[0] - idx);
          got_last = tx_last;
          idx++;
          waited = 0;
        end else begin
          waited++;
          if (waited > TIMEOUT) begin
            report_timeout("The transmit stream stopped before the packet ended.");
          end
        end
      end

      // Far end answers a few cycles later, nothing may leave meanwhile
      delay = $unsigned($random(seed)) % 6;
      for (int d = 0; d < delay; d++) begin
        @(negedge clock);
        tx_ready = (($random(seed) & 3) != 0);
        #1;
        check_value($sformatf("packet %0d idle before response", pkt), 0, tx_valid);
      end
      @(negedge clock);
      resp_valid = 1'b1;
      resp_code  = (($random(seed) & 3) == 0) ? pkt_pkg::ACK_NAK : pkt_pkg::ACK_OK;
      #1;
      check_value($sformatf("packet %0d idle at response", pkt), 0, tx_valid);

      // NAK keeps the packet at the head for an identical resend
      if (resp_code == pkt_pkg::ACK_OK) begin
        for (int i = 0; i < exp_len[0]; i++) begin
          void'(exp_data.pop_front());
        end
        void'(exp_len.pop_front());
        pkt++;
      end
    end
    @(negedge clock);
    resp_valid = 1'b0;
    // Anything that still leaks out stays visible on tx
    tx_ready   = 1'b0;
  endtask

  initial begin
    seed             = 3;
    saw_backpressure = 1'b0;
    reset            = 1'b1;
    rx_valid         = 1'b0;
    rx_last          = 1'b0;
    rx_data          = '0;
    tx_ready         = 1'b0;
    resp_valid       = 1'b0;
    resp_code        = pkt_pkg::ACK_OK;

    build_frames();

    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    fork
      drive_rx();
      receive_tx();
    join

    check_value("rx back-pressure seen", 1, saw_backpressure);

    // Everything released, the link must stay quiet
    for (int i = 0; i < 20; i++) begin
      @(negedge clock);
      tx_ready = 1'b1;
      #1;
      check_value("final level", 0, level);
      check_value("final tx_valid", 0, tx_valid);
    end

    check_value("assertion failures", 0, i_dut.u_link_props.fail_count);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: src.f
hw/pkt_pkg.sv
hw/crc_check.sv
hw/packet_fifo.sv
hw/ack_tracker.sv
hw/link_buffer.sv
sim/link_properties.sv
sim/link_tb.sv
